/* all.f */
+incdir+hdl
hdl/procPkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/hazardUnit.sv
hdl/proc.sv
bench/clockGen.sv
bench/procTb.sv

/* bench/clockGen.sv */
/* 8 ns clock. rstN stays low while holdReset is high and for two more
   cycles after it drops, and only changes on the falling edge */
`timescale 1ns/1ps

module clockGen (
    input  logic holdReset,
    output logic clk,
    output logic rstN
);

    int lowCycles;

    initial begin
        clk       = 1'b0;
        rstN      = 1'b0;
        lowCycles = 0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (holdReset) begin
            lowCycles <= 0;
        end else if (lowCycles < 2) begin
            lowCycles <= lowCycles + 1;
        end
    end

    always @(negedge clk) begin
        rstN <= (lowCycles >= 2);
    end

endmodule

/* bench/procTb.sv */
/* Directed tests for the core. The register file has no reset, so programs
   clear their registers with XOR. Data memory is a 256-word model indexed
   by addr[7:0] that answers the req/ack port after LFSR-chosen delays */
`timescale 1ns/1ps

module procTb;

    localparam int clkPeriod      = 8;
    localparam int testCycleBound = 100 + 2 * 200 + 3 * 250 + 200 + 150 + 200;
    localparam int maxAckDelay    = 7 + 3;                  // Ack rise plus ack release
    localparam int watchdogNs     = testCycleBound * maxAckDelay * clkPeriod;
    localparam int quietCycles    = 40;

    logic              clk;
    logic              rstN;
    logic              holdReset;
    logic              imemWe;
    procPkg::imemAddrT imemAddr;
    procPkg::wordT     imemData;
    procPkg::dmemReqT  dmemReq;
    logic              req;
    logic              ack;
    procPkg::wordT     rdata;
    logic              halted;
    logic              err;

    logic [31:0]       lfsrState;
    procPkg::wordT     dataMem [256];
    procPkg::wordT     progWords[$];
    procPkg::dmemReqT  observed[$];          // Accesses seen on the port
    procPkg::dmemReqT  expected[$];

    clockGen clockGen_i (.holdReset(holdReset), .clk(clk), .rstN(rstN));

    proc proc_i (
        .clk(clk), .rstN(rstN),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .dmemReq(dmemReq), .req(req), .ack(ack), .rdata(rdata),
        .halted(halted), .err(err)
    );

    // Right-shifting Galois LFSR, one step per bit
    function automatic logic lfsrBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return outBit;
    endfunction

    function automatic int randomBits(int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsrBit());
        end
        return value;
    endfunction

    function automatic procPkg::wordT sext6(int imm);
        logic [5:0] field;
        field = 6'(imm);
        return {{10{field[5]}}, field};
    endfunction

    // Odd multiplier so every index bit shows in the word
    function automatic procPkg::wordT fillWord(int addr);
        return 16'(addr * 40503) ^ 16'h5a3c;
    endfunction

    task automatic addR(procPkg::opcodeT op, int rd, int rs, int rt);
        progWords.push_back({op, 3'(rd), 3'(rs), 3'(rt), 3'b000});
    endtask

    task automatic addI(procPkg::opcodeT op, int rd, int rs, int imm);
        progWords.push_back({op, 3'(rd), 3'(rs), 6'(imm)});
    endtask

    task automatic failRun();
        $display("tests failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic checkWord(procPkg::wordT got, procPkg::wordT exp, string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
            failRun();
        end
    endtask

    task automatic checkReq(procPkg::dmemReqT got, procPkg::dmemReqT exp, string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got addr %h wdata %h we %b expected addr %h wdata %h we %b",
                     $time, what, got.addr, got.wdata, got.we, exp.addr, exp.wdata, exp.we);
            failRun();
        end
    endtask

    task automatic checkFlag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got %b expected %b", $time, what, got, exp);
            failRun();
        end
    endtask

    task automatic expectAccess(procPkg::wordT addr, procPkg::wordT wdata, logic we);
        procPkg::dmemReqT rec;
        rec.addr  = addr;
        rec.wdata = we ? wdata : '0;      // Load payload is not compared
        rec.we    = we;
        expected.push_back(rec);
    endtask

    task automatic checkAccesses(string name);
        checkWord(16'(observed.size()), 16'(expected.size()), {name, " access count"});
        foreach (expected[i]) begin
            checkReq(observed[i], expected[i], $sformatf("%s access %0d", name, i));
        end
    endtask

    // Hold the core in reset, refill the model and write the program
    task automatic loadProgram();
        @(negedge clk);
        holdReset = 1'b1;
        @(negedge clk);
        while (rstN) @(negedge clk);
        for (int a = 0; a < 256; a++) begin
            dataMem[a] = fillWord(a);
        end
        observed.delete();
        expected.delete();
        foreach (progWords[i]) begin
            imemWe   = 1'b1;
            imemAddr = procPkg::imemAddrT'(i);
            imemData = progWords[i];
            @(negedge clk);
        end
        imemWe = 1'b0;
    endtask

    // Returns in the first cycle with rstN high
    task automatic releaseReset();
        holdReset = 1'b0;
        @(negedge clk);
        while (!rstN) @(negedge clk);
    endtask

    task automatic runProgram();
        loadProgram();
        releaseReset();
        while (!halted) @(negedge clk);
    endtask

    task automatic testResetState();
        progWords.delete();
        addR(procPkg::opNop, 0, 0, 0);
        addR(procPkg::opHalt, 0, 0, 0);
        loadProgram();
        checkFlag(req, 1'b0, "req in reset");
        checkFlag(halted, 1'b0, "halted in reset");
        checkFlag(err, 1'b0, "err in reset");
        releaseReset();
        checkFlag(req, 1'b0, "req after reset");
        checkFlag(halted, 1'b0, "halted after reset");
        checkFlag(err, 1'b0, "err after reset");
        while (!halted) @(negedge clk);
        checkAccesses("reset");
    endtask

    task automatic testAlu();
        procPkg::wordT a;
        procPkg::wordT b;
        int immA;
        int immB;
        int immC;
        for (int round = 0; round < 2; round++) begin
            immA = randomBits(6);
            immB = randomBits(6);
            immC = randomBits(6);
            a    = sext6(immA);
            b    = sext6(immB);
            progWords.delete();
            addR(procPkg::opXor, 0, 0, 0);
            addR(procPkg::opXor, 1, 1, 1);
            addI(procPkg::opAddi, 1, 1, immA);      // Back-to-back on r1
            addR(procPkg::opXor, 2, 2, 2);
            addI(procPkg::opAddi, 2, 2, immB);
            addR(procPkg::opAdd, 3, 1, 2);
            addR(procPkg::opSub, 4, 1, 2);
            addR(procPkg::opAnd, 5, 1, 2);
            addR(procPkg::opXor, 6, 1, 2);
            for (int r = 3; r <= 6; r++) begin
                addI(procPkg::opSt, r, 0, 13 + r);
            end
            addI(procPkg::opAddi, 7, 6, immC);
            addI(procPkg::opSt, 7, 0, 20);          // Store right behind its producer
            addR(procPkg::opHalt, 0, 0, 0);
            runProgram();
            expectAccess(16'd16, a + b, 1'b1);
            expectAccess(16'd17, a - b, 1'b1);
            expectAccess(16'd18, a & b, 1'b1);
            expectAccess(16'd19, a ^ b, 1'b1);
            expectAccess(16'd20, (a ^ b) + sext6(immC), 1'b1);
            checkAccesses("alu");
            checkFlag(err, 1'b0, "err after alu program");
        end
    endtask

    task automatic testLoadStore();
        procPkg::wordT vA;
        procPkg::wordT vB;
        int la;
        int lb;
        for (int round = 0; round < 3; round++) begin
            la = randomBits(4);
            lb = randomBits(4);
            vA = fillWord(la);
            vB = fillWord(lb);
            progWords.delete();
            addR(procPkg::opXor, 0, 0, 0);
            addI(procPkg::opLd, 1, 0, la);
            addI(procPkg::opLd, 2, 0, lb);
            addI(procPkg::opSt, 1, 0, 20);          // Load-use
            addR(procPkg::opAdd, 3, 1, 2);
            addI(procPkg::opSt, 3, 0, 21);
            addI(procPkg::opSt, 2, 0, la);
            addI(procPkg::opLd, 5, 0, la);          // Reads the word just stored
            addI(procPkg::opSt, 5, 0, 22);
            addR(procPkg::opHalt, 0, 0, 0);
            runProgram();
            expectAccess(16'(la), '0, 1'b0);
            expectAccess(16'(lb), '0, 1'b0);
            expectAccess(16'd20, vA, 1'b1);
            expectAccess(16'd21, vA + vB, 1'b1);
            expectAccess(16'(la), vB, 1'b1);
            expectAccess(16'(la), '0, 1'b0);
            expectAccess(16'd22, vB, 1'b1);
            checkAccesses("load/store");
        end
    endtask

    task automatic testBranches();
        progWords.delete();
        addR(procPkg::opXor, 0, 0, 0);
        addR(procPkg::opXor, 1, 1, 1);
        addI(procPkg::opAddi, 1, 1, 1);
        addI(procPkg::opBeqz, 0, 0, 1);             // Taken, lands on 5
        addI(procPkg::opSt, 1, 0, 8);
        addI(procPkg::opBeqz, 0, 1, 1);             // r1 is 1, falls through
        addI(procPkg::opSt, 1, 0, 9);
        addI(procPkg::opBeqz, 0, 0, 2);             // Taken, lands on 10
        addI(procPkg::opSt, 1, 0, 10);
        addI(procPkg::opSt, 1, 0, 11);
        addI(procPkg::opSt, 1, 0, 12);
        addR(procPkg::opHalt, 0, 0, 0);
        runProgram();
        expectAccess(16'd9, 16'd1, 1'b1);
        expectAccess(16'd12, 16'd1, 1'b1);
        checkAccesses("branch");
        checkFlag(err, 1'b0, "err after branch program");
    endtask

    task automatic testIllegal();
        int cycle;
        int errCycle;
        progWords.delete();
        addR(procPkg::opXor, 0, 0, 0);
        addR(procPkg::opXor, 1, 1, 1);
        addI(procPkg::opAddi, 1, 1, 6);
        addI(procPkg::opSt, 1, 0, 4);
        progWords.push_back(16'hc000);              // Opcode 12 is undefined
        addI(procPkg::opSt, 1, 0, 5);
        addR(procPkg::opHalt, 0, 0, 0);
        loadProgram();
        releaseReset();
        cycle    = 0;
        errCycle = -1;
        while (!halted) begin
            if (err && errCycle < 0) begin
                errCycle = cycle;
            end
            cycle++;
            @(negedge clk);
        end
        checkFlag(errCycle >= 0, 1'b1, "err raised before halted");
        checkFlag(err, 1'b1, "err held after halt");
        expectAccess(16'd4, 16'd6, 1'b1);
        checkAccesses("illegal");
    endtask

    task automatic testHalt();
        progWords.delete();
        addR(procPkg::opXor, 0, 0, 0);
        addR(procPkg::opXor, 1, 1, 1);
        addI(procPkg::opAddi, 1, 1, 5);
        addI(procPkg::opSt, 1, 0, 3);
        addR(procPkg::opHalt, 0, 0, 0);
        addI(procPkg::opSt, 1, 0, 4);               // Never issued
        runProgram();
        repeat (quietCycles) begin
            @(negedge clk);
            checkFlag(req, 1'b0, "req after halt");
            checkFlag(halted, 1'b1, "halted holds");
        end
        expectAccess(16'd3, 16'd5, 1'b1);
        checkAccesses("halt");
        checkFlag(err, 1'b0, "err after halt program");
    endtask

    // Four-phase slave on the data port
    initial begin : dataResponder
        procPkg::dmemReqT snap;
        int delay;
        ack   = 1'b0;
        rdata = '0;
        forever begin
            @(negedge clk);
            if (rstN && req && !ack) begin
                snap  = dmemReq;
                delay = randomBits(3);
                repeat (delay) @(negedge clk);
                checkReq(dmemReq, snap, "request held before ack");
                if (snap.we) begin
                    dataMem[snap.addr[7:0]] = snap.wdata;
                end else begin
                    rdata      = dataMem[snap.addr[7:0]];
                    snap.wdata = '0;
                end
                observed.push_back(snap);
                ack = 1'b1;
                while (req) @(negedge clk);
                repeat (randomBits(2)) @(negedge clk);
                ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(watchdogNs);
        $display("Timeout: the tests did not finish within %0d ns", watchdogNs);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : mainSequence
        lfsrState = 32'h578f1b0f;
        holdReset = 1'b1;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        testResetState();
        testAlu();
        testLoadStore();
        testBranches();
        testIllegal();
        testHalt();
        $display("all tests passed");
        $finish;
    end

endmodule

/* hdl/decode.sv */
/* Decode, write-first register file and BEQZ resolution. No forwarding;
   a stall injects a bubble into ID/EX, a memory hold freezes it.
   Illegal opcodes travel on as HALT */
`timescale 1ns/1ps
`include "proc_defs.svh"

module decode (
    input  logic             clk,
    input  logic             rstN,
    input  procPkg::ifIdT    ifId,
    input  procPkg::memWbT   memWb,
    input  logic             stall,
    input  logic             hold,
    output procPkg::idExT    idEx,
    output logic             branchTaken,
    output procPkg::wordT    branchTarget,
    output procPkg::regIdxT  srcRs,
    output procPkg::regIdxT  srcRt,
    output logic             useRt,
    output logic             isHalt,
    output logic             illegal
);

    procPkg::wordT    regs [`PROC_NREGS];
    procPkg::opcodeT  op;
    procPkg::regIdxT  rd;
    procPkg::wordT    imm;
    procPkg::wordT    rsVal;
    procPkg::wordT    rtVal;
    logic             wbWrite;
    logic             legal;
    logic             regWr;
    logic             usesRt;

    assign op  = procPkg::opcodeT'(ifId.instr[15:12]);
    assign rd  = ifId.instr[11:9];
    assign imm = {{(`PROC_WIDTH-6){ifId.instr[5]}}, ifId.instr[5:0]};

    always_comb begin
        legal  = 1'b1;
        regWr  = 1'b0;
        usesRt = 1'b0;
        case (op)
            procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor: begin
                regWr  = 1'b1;
                usesRt = 1'b1;
            end
            procPkg::opAddi, procPkg::opLd: regWr = 1'b1;
            procPkg::opSt: usesRt = 1'b1;          // Store data comes from rd
            procPkg::opNop, procPkg::opBeqz, procPkg::opHalt: legal = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    // Source fields for the interlock
    assign srcRs = ifId.instr[8:6];
    assign srcRt = (op == procPkg::opSt) ? rd : procPkg::regIdxT'(ifId.instr[5:3]);
    assign useRt = ifId.valid && usesRt;

    assign isHalt  = ifId.valid && (op == procPkg::opHalt || !legal);
    assign illegal = ifId.valid && !legal;

    // Writeback port, written before decode reads
    assign wbWrite = memWb.valid && memWb.regWrite;

    always_ff @(posedge clk) begin
        if (wbWrite) begin
            regs[memWb.rd] <= memWb.result;
        end
    end

    assign rsVal = (wbWrite && memWb.rd == srcRs) ? memWb.result : regs[srcRs];
    assign rtVal = (wbWrite && memWb.rd == srcRt) ? memWb.result : regs[srcRt];

    // Only resolve once the rs value is current
    assign branchTaken  = ifId.valid && op == procPkg::opBeqz && rsVal == '0 && !stall;
    assign branchTarget = ifId.pc + 1'b1 + imm;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (hold) begin
            idEx <= idEx;
        end else if (stall) begin
            idEx <= '0;                            // Bubble
        end else begin
            idEx.valid    <= ifId.valid;
            idEx.op       <= legal ? op : procPkg::opHalt;
            idEx.rd       <= rd;
            idEx.rsVal    <= rsVal;
            idEx.rtVal    <= rtVal;
            idEx.imm      <= imm;
            idEx.regWrite <= ifId.valid && regWr;
        end
    end

    // Writes come from a valid writeback and stay inside the file
    assert property (@(posedge clk) disable iff (!rstN)
        memWb.regWrite |-> memWb.valid && (int'(memWb.rd) < `PROC_NREGS));

endmodule

/* hdl/execute.sv */
/* ALU and effective address adder feeding the EX/MEM register.
   LD and ST use rs + imm, BEQZ and HALT pass through with no result */
`timescale 1ns/1ps

module execute (
    input  logic            clk,
    input  logic            rstN,
    input  procPkg::idExT   idEx,
    input  logic            hold,
    output procPkg::exMemT  exMem
);

    procPkg::wordT aluOut;

    always_comb begin
        case (idEx.op)
            procPkg::opAdd:  aluOut = idEx.rsVal + idEx.rtVal;
            procPkg::opSub:  aluOut = idEx.rsVal - idEx.rtVal;
            procPkg::opAnd:  aluOut = idEx.rsVal & idEx.rtVal;
            procPkg::opXor:  aluOut = idEx.rsVal ^ idEx.rtVal;
            procPkg::opAddi,
            procPkg::opLd,
            procPkg::opSt:   aluOut = idEx.rsVal + idEx.imm;    // Also the address
            default:         aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMem <= '0;
        end else if (hold) begin
            exMem <= exMem;                     // Access in flight downstream
        end else begin
            exMem.valid     <= idEx.valid;
            exMem.op        <= idEx.op;
            exMem.rd        <= idEx.rd;
            exMem.aluOut    <= aluOut;
            exMem.storeData <= idEx.rtVal;
            exMem.regWrite  <= idEx.regWrite;
        end
    end

endmodule

/* hdl/fetch.sv */
/* PC, instruction memory and IF/ID register. The load port writes only
   while rstN is low. A hold or stall has priority over a taken branch */
`timescale 1ns/1ps
`include "proc_defs.svh"

module fetch (
    input  logic              clk,
    input  logic              rstN,
    input  logic              imemWe,
    input  procPkg::imemAddrT imemAddr,
    input  procPkg::wordT     imemData,
    input  logic              stall,        // Decode interlock
    input  logic              hold,         // Memory stall
    input  logic              branchTaken,
    input  procPkg::wordT     branchTarget,
    input  logic              stopFetch,
    output procPkg::ifIdT     ifId
);

    procPkg::wordT imem [`PROC_IMEM_DEPTH];
    procPkg::wordT pc;
    procPkg::wordT instr;

    // Program load, no reset on the array
    always_ff @(posedge clk) begin
        if (!rstN && imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    // Word addressed, upper PC bits ignored
    assign instr = imem[pc[$clog2(`PROC_IMEM_DEPTH)-1:0]];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc   <= `PROC_WIDTH'(`PROC_RESET_PC);
            ifId <= '0;
        end else if (stall || hold) begin
            pc   <= pc;                      // Keep PC and IF/ID
            ifId <= ifId;
        end else if (branchTaken) begin
            pc   <= branchTarget;
            ifId <= '0;                      // Squash the shadow slot
        end else if (stopFetch) begin
            ifId <= '0;                      // HALT seen, issue nothing more
        end else begin
            pc         <= pc + 1'b1;
            ifId.valid <= 1'b1;
            ifId.pc    <= pc;
            ifId.instr <= instr;
        end
    end

endmodule

/* hdl/hazardUnit.sv */
/* RAW interlock against ID/EX and EX/MEM only; writeback is covered by the
   write-first register file. Halt and error flags are sticky until reset */
`timescale 1ns/1ps

module hazardUnit (
    input  logic            clk,
    input  logic            rstN,
    input  procPkg::regIdxT srcRs,
    input  procPkg::regIdxT srcRt,
    input  logic            useRt,
    input  logic            isHalt,
    input  logic            illegal,
    input  procPkg::idExT   idEx,
    input  procPkg::exMemT  exMem,
    input  procPkg::memWbT  memWb,
    output logic            stallId,
    output logic            stopFetch,
    output logic            halted,
    output logic            err
);

    logic stopQ;
    logic errQ;
    logic rsHit;
    logic rtHit;

    function automatic logic pending(procPkg::regIdxT src, logic valid, logic wr,
                                     procPkg::regIdxT dst);
        return valid && wr && src == dst;
    endfunction

    assign rsHit = pending(srcRs, idEx.valid, idEx.regWrite, idEx.rd)
                || pending(srcRs, exMem.valid, exMem.regWrite, exMem.rd);
    assign rtHit = pending(srcRt, idEx.valid, idEx.regWrite, idEx.rd)
                || pending(srcRt, exMem.valid, exMem.regWrite, exMem.rd);

    assign stallId = rsHit || (useRt && rtHit);

    assign stopFetch = stopQ || isHalt;        // Squash the slot behind HALT too
    assign err       = errQ || illegal;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stopQ  <= 1'b0;
            errQ   <= 1'b0;
            halted <= 1'b0;
        end else begin
            stopQ  <= stopQ || isHalt;
            errQ   <= errQ || illegal;
            halted <= halted || (memWb.valid && memWb.halt);   // HALT left writeback
        end
    end

endmodule

/* hdl/memory.sv */
/* Four-phase data port master and MEM/WB register. memStall holds the
   pipeline from LD/ST entry until the cycle after ack falls. A new req
   waits for ack to be low */
`timescale 1ns/1ps

module memory (
    input  logic             clk,
    input  logic             rstN,
    input  procPkg::exMemT   exMem,
    output logic             memStall,
    output procPkg::dmemReqT dmemReq,
    output logic             req,
    input  logic             ack,
    input  procPkg::wordT    rdata,
    output procPkg::memWbT   memWb
);

    typedef enum logic [1:0] {sIdle, sWaitAck, sWaitRelease} memStateT;

    memStateT      state;
    logic          isMemOp;
    logic          done;        // Handshake finished, release the pipeline
    procPkg::wordT loadQ;

    assign isMemOp  = exMem.op == procPkg::opLd || exMem.op == procPkg::opSt;
    assign memStall = exMem.valid && isMemOp && !done;

    // Stable because exMem is frozen while the access runs
    assign dmemReq = '{addr: exMem.aluOut, wdata: exMem.storeData,
                       we: exMem.op == procPkg::opSt};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sIdle;
            req   <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                sIdle: if (memStall && !ack) begin
                    req   <= 1'b1;
                    state <= sWaitAck;
                end
                sWaitAck: if (ack) begin
                    req   <= 1'b0;
                    state <= sWaitRelease;
                end
                sWaitRelease: if (!ack) begin
                    done  <= 1'b1;
                    state <= sIdle;
                end
                default: state <= sIdle;
            endcase
        end
    end

    // Load word is valid alongside ack
    always_ff @(posedge clk) begin
        if (state == sWaitAck && ack) begin
            loadQ <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb.valid    <= exMem.valid && !memStall;
            memWb.rd       <= exMem.rd;
            memWb.result   <= (exMem.op == procPkg::opLd) ? loadQ : exMem.aluOut;
            memWb.regWrite <= exMem.valid && exMem.regWrite && !memStall;
            memWb.halt     <= exMem.valid && exMem.op == procPkg::opHalt && !memStall;
        end
    end

    // req only drops after ack has risen
    assert property (@(posedge clk) disable iff (!rstN) req && !ack |=> req);

    // Request payload frozen for the whole req phase
    assert property (@(posedge clk) disable iff (!rstN) req |=> !req || $stable(dmemReq));

endmodule

/* hdl/proc.sv */
/* Five-stage 16-bit core without forwarding; RAW hazards stall decode.
   Instruction memory loads only while rstN is low. The data port is a
   four-phase req/ack master and a slow ack freezes the whole pipeline */
`timescale 1ns/1ps

module proc (
    input  logic              clk,
    input  logic              rstN,
    input  logic              imemWe,
    input  procPkg::imemAddrT imemAddr,
    input  procPkg::wordT     imemData,
    output procPkg::dmemReqT  dmemReq,
    output logic              req,
    input  logic              ack,
    input  procPkg::wordT     rdata,
    output logic              halted,
    output logic              err
);

    procPkg::ifIdT  ifId;
    procPkg::idExT  idEx;
    procPkg::exMemT exMem;
    procPkg::memWbT memWb;

    logic           stallId;        // RAW interlock
    logic           memStall;       // Data access in flight
    logic           stopFetch;
    logic           branchTaken;
    procPkg::wordT  branchTarget;
    procPkg::regIdxT srcRs;
    procPkg::regIdxT srcRt;
    logic           useRt;
    logic           isHalt;
    logic           illegal;

    fetch fetch_i (
        .clk(clk), .rstN(rstN),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .stall(stallId), .hold(memStall),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .stopFetch(stopFetch), .ifId(ifId)
    );

    decode decode_i (
        .clk(clk), .rstN(rstN), .ifId(ifId), .memWb(memWb),
        .stall(stallId), .hold(memStall), .idEx(idEx),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .srcRs(srcRs), .srcRt(srcRt), .useRt(useRt),
        .isHalt(isHalt), .illegal(illegal)
    );

    execute execute_i (
        .clk(clk), .rstN(rstN), .idEx(idEx), .hold(memStall), .exMem(exMem)
    );

    memory memory_i (
        .clk(clk), .rstN(rstN), .exMem(exMem), .memStall(memStall),
        .dmemReq(dmemReq), .req(req), .ack(ack), .rdata(rdata), .memWb(memWb)
    );

    hazardUnit hazardUnit_i (
        .clk(clk), .rstN(rstN),
        .srcRs(srcRs), .srcRt(srcRt), .useRt(useRt),
        .isHalt(isHalt), .illegal(illegal),
        .idEx(idEx), .exMem(exMem), .memWb(memWb),
        .stallId(stallId), .stopFetch(stopFetch),
        .halted(halted), .err(err)
    );

endmodule

/* hdl/procPkg.sv */
/* Shared types of the core. Opcode values are fixed encodings of instr[15:12];
   codes above opHalt are illegal */
`include "proc_defs.svh"

package procPkg;

    typedef logic [`PROC_WIDTH-1:0] wordT;
    typedef logic [$clog2(`PROC_NREGS)-1:0] regIdxT;
    typedef logic [$clog2(`PROC_IMEM_DEPTH)-1:0] imemAddrT;

    typedef enum logic [3:0] {
        opNop  = 4'd0,
        opAdd  = 4'd1,
        opSub  = 4'd2,
        opAnd  = 4'd3,
        opXor  = 4'd4,
        opAddi = 4'd5,
        opLd   = 4'd6,   // rd <= mem[rs + imm]
        opSt   = 4'd7,   // mem[rs + imm] <= rd
        opBeqz = 4'd8,   // Resolved in decode
        opHalt = 4'd9
    } opcodeT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        logic   valid;
        opcodeT op;
        regIdxT rd;
        wordT   rsVal;
        wordT   rtVal;     // rd value for ST
        wordT   imm;       // Sign extended imm6
        logic   regWrite;
    } idExT;

    typedef struct packed {
        logic   valid;
        opcodeT op;
        regIdxT rd;
        wordT   aluOut;    // Also the data address
        wordT   storeData;
        logic   regWrite;
    } exMemT;

    typedef struct packed {
        logic   valid;
        regIdxT rd;
        wordT   result;
        logic   regWrite;
        logic   halt;
    } memWbT;

    typedef struct packed {
        wordT addr;
        wordT wdata;
        logic we;
    } dmemReqT;

endpackage

/* hdl/proc_defs.svh */
/* Widths and sizes for the 16-bit core. Register index and imem address
   widths are derived from the counts with $clog2 */
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// Data and instruction word
`define PROC_WIDTH 16

// Architectural registers
`define PROC_NREGS 8

// Instruction memory words
`define PROC_IMEM_DEPTH 64

// PC after reset
`define PROC_RESET_PC 0

`endif

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module procTb -f all.f -o procSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/procSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
